// File: hdl/axil_read_to_banks.sv
// ----------------------------------------------------------------------
// AXI4-Lite read converter: accepts AR, reads all four lanes from the
// banks, gathers the lane data into one word and returns it on R.
// ----------------------------------------------------------------------
module axil_read_to_banks import mem_pkg::*; #(
  parameter int unsigned AddrWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  input  logic [AddrWidth-1:0] araddr_i,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  output word_t                rdata_o,
  output resp_t                rresp_o,
  output bank_vec_t            lane_req_o,
  output logic [AddrWidth-3:0] lane_addr_o,
  input  bank_vec_t            lane_gnt_i,
  input  bank_vec_t            lane_rvalid_i,
  input  lane_t [NumBanks-1:0] lane_rdata_i
);

  conv_state_e          state_q, state_d;
  bank_vec_t            pending_q, pending_d;
  bank_vec_t            outstanding_q, outstanding_d;
  logic [AddrWidth-3:0] addr_q;
  word_t                rdata_q;
  logic                 ar_fire;
  bank_vec_t            lane_fire;

  assign ar_fire   = (state_q == IDLE) & arvalid_i;
  assign arready_o = ar_fire;

  assign lane_req_o  = (state_q == ISSUE) ? pending_q : '0;
  assign lane_addr_o = addr_q;
  assign lane_fire   = lane_req_o & lane_gnt_i;

  assign rvalid_o = (state_q == RESP);
  assign rdata_o  = rdata_q;
  assign rresp_o  = RespOkay;

  always_comb begin
    state_d       = state_q;
    pending_d     = pending_q & ~lane_fire;
    outstanding_d = (outstanding_q | lane_fire) & ~lane_rvalid_i;
    case (state_q)
      IDLE: begin
        // A read always needs every lane of the word.
        if (ar_fire) begin
          pending_d     = '1;
          outstanding_d = '0;
          state_d       = ISSUE;
        end
      end
      ISSUE: begin
        if (pending_d == '0) begin
          state_d = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if ((pending_d | outstanding_d) == '0) begin
          state_d = RESP;
        end
      end
      RESP: begin
        // The gathered word stays on R until the master takes it.
        if (rready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= IDLE;
      pending_q     <= '0;
      outstanding_q <= '0;
    end else begin
      state_q       <= state_d;
      pending_q     <= pending_d;
      outstanding_q <= outstanding_d;
    end
  end

  // Lanes can return in any order, so each one lands in its own byte.
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      addr_q <= araddr_i[AddrWidth-1:2];
    end
    for (int i = 0; i < NumBanks; i++) begin
      if (lane_rvalid_i[i]) begin
        rdata_q[i*LaneWidth +: LaneWidth] <= lane_rdata_i[i];
      end
    end
  end

endmodule

// File: hdl/axil_to_mem_interleaved.sv
// ----------------------------------------------------------------------
// AXI4-Lite to banked memory with separate read and write converters,
// so reads may overtake writes. Each bank has its own arbiter.
// ----------------------------------------------------------------------
module axil_to_mem_interleaved import mem_pkg::*; #(
  parameter int unsigned AddrWidth = 8
) (
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                awvalid_i,
  output logic                                awready_o,
  input  logic [AddrWidth-1:0]                awaddr_i,
  input  logic                                wvalid_i,
  output logic                                wready_o,
  input  word_t                               wdata_i,
  input  strb_t                               wstrb_i,
  output logic                                bvalid_o,
  input  logic                                bready_i,
  output resp_t                               bresp_o,
  input  logic                                arvalid_i,
  output logic                                arready_o,
  input  logic [AddrWidth-1:0]                araddr_i,
  output logic                                rvalid_o,
  input  logic                                rready_i,
  output word_t                               rdata_o,
  output resp_t                               rresp_o,
  output bank_vec_t                           mem_req_o,
  output logic [NumBanks-1:0][AddrWidth-3:0] mem_addr_o,
  output lane_t [NumBanks-1:0]                mem_wdata_o,
  output bank_vec_t                           mem_strb_o,
  output bank_vec_t                           mem_we_o,
  input  bank_vec_t                           mem_gnt_i,
  input  bank_vec_t                           mem_rvalid_i,
  input  lane_t [NumBanks-1:0]                mem_rdata_i
);

  // Lane buses of the write side.
  bank_vec_t            w_lane_req, w_lane_gnt, w_lane_rvalid;
  logic [AddrWidth-3:0] w_lane_addr;
  lane_t [NumBanks-1:0] w_lane_wdata;
  // Lane buses of the read side.
  bank_vec_t            r_lane_req, r_lane_gnt, r_lane_rvalid;
  logic [AddrWidth-3:0] r_lane_addr;

  // The AW, W and B ports connect by name, only the lane side is listed.
  axil_write_to_banks #(
    .AddrWidth(AddrWidth)
  ) axil_write_to_banks_i (
    .*,
    .lane_req_o   (w_lane_req),
    .lane_addr_o  (w_lane_addr),
    .lane_wdata_o (w_lane_wdata),
    .lane_gnt_i   (w_lane_gnt),
    .lane_rvalid_i(w_lane_rvalid)
  );

  // Bank read data is broadcast, the arbiter decides who sees rvalid.
  axil_read_to_banks #(
    .AddrWidth(AddrWidth)
  ) axil_read_to_banks_i (
    .*,
    .lane_req_o   (r_lane_req),
    .lane_addr_o  (r_lane_addr),
    .lane_gnt_i   (r_lane_gnt),
    .lane_rvalid_i(r_lane_rvalid),
    .lane_rdata_i (mem_rdata_i)
  );

  // Unstrobed lanes never request, so the write grant is the lane strobe.
  assign mem_strb_o = w_lane_gnt;

  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank_arb
    bank_port_arbiter #(
      .AddrWidth(AddrWidth)
    ) bank_port_arbiter_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .rd_req_i    (r_lane_req[i]),
      .rd_addr_i   (r_lane_addr),
      .rd_gnt_o    (r_lane_gnt[i]),
      .rd_rvalid_o (r_lane_rvalid[i]),
      .wr_req_i    (w_lane_req[i]),
      .wr_addr_i   (w_lane_addr),
      .wr_wdata_i  (w_lane_wdata[i]),
      .wr_gnt_o    (w_lane_gnt[i]),
      .wr_rvalid_o (w_lane_rvalid[i]),
      .mem_req_o   (mem_req_o[i]),
      .mem_addr_o  (mem_addr_o[i]),
      .mem_wdata_o (mem_wdata_o[i]),
      .mem_we_o    (mem_we_o[i]),
      .mem_gnt_i   (mem_gnt_i[i]),
      .mem_rvalid_i(mem_rvalid_i[i])
    );
  end

endmodule

// File: hdl/axil_write_to_banks.sv
// ----------------------------------------------------------------------
// AXI4-Lite write converter: joins AW and W, issues strobed lane writes
// to the banks and answers on B once every requested lane has responded.
// ----------------------------------------------------------------------
module axil_write_to_banks import mem_pkg::*; #(
  parameter int unsigned AddrWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  logic [AddrWidth-1:0] awaddr_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  word_t                wdata_i,
  input  strb_t                wstrb_i,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  output resp_t                bresp_o,
  output bank_vec_t            lane_req_o,
  output logic [AddrWidth-3:0] lane_addr_o,
  output lane_t [NumBanks-1:0] lane_wdata_o,
  input  bank_vec_t            lane_gnt_i,
  input  bank_vec_t            lane_rvalid_i
);

  conv_state_e          state_q, state_d;
  // Lanes still to be granted.
  bank_vec_t            pending_q, pending_d;
  // Lanes granted but not yet answered by their bank.
  bank_vec_t            outstanding_q, outstanding_d;
  logic [AddrWidth-3:0] addr_q;
  word_t                wdata_q;
  logic                 aw_w_fire;
  bank_vec_t            lane_fire;

  // AW and W are only taken together, and only while idle.
  assign aw_w_fire = (state_q == IDLE) & awvalid_i & wvalid_i;
  assign awready_o = aw_w_fire;
  assign wready_o  = aw_w_fire;

  // Each 8-bit lane has exactly one strobe bit, so a lane with a clear
  // strobe is simply never requested.
  assign lane_req_o   = (state_q == ISSUE) ? pending_q : '0;
  assign lane_addr_o  = addr_q;
  assign lane_wdata_o = wdata_q;
  assign lane_fire    = lane_req_o & lane_gnt_i;

  assign bvalid_o = (state_q == RESP);
  assign bresp_o  = RespOkay;

  always_comb begin
    state_d       = state_q;
    pending_d     = pending_q & ~lane_fire;
    // A bank answers one cycle after the grant, so a lane never sees its
    // grant and its response in the same cycle.
    outstanding_d = (outstanding_q | lane_fire) & ~lane_rvalid_i;
    case (state_q)
      IDLE: begin
        if (aw_w_fire) begin
          pending_d     = bank_vec_t'(wstrb_i);
          outstanding_d = '0;
          // With no strobe at all the write completes right away.
          state_d       = (wstrb_i == '0) ? RESP : ISSUE;
        end
      end
      ISSUE: begin
        if (pending_d == '0) begin
          state_d = WAIT_RSP;
        end
      end
      WAIT_RSP: begin
        if ((pending_d | outstanding_d) == '0) begin
          state_d = RESP;
        end
      end
      RESP: begin
        if (bready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= IDLE;
      pending_q     <= '0;
      outstanding_q <= '0;
    end else begin
      state_q       <= state_d;
      pending_q     <= pending_d;
      outstanding_q <= outstanding_d;
    end
  end

  // Word index and data are held for the whole transaction.
  always_ff @(posedge clk_i) begin
    if (aw_w_fire) begin
      addr_q  <= awaddr_i[AddrWidth-1:2];
      wdata_q <= wdata_i;
    end
  end

endmodule

// File: hdl/bank_port_arbiter.sv
// ----------------------------------------------------------------------
// Two-input round-robin arbiter in front of one memory bank, with a
// small FIFO that steers each bank response back to the winning side.
// ----------------------------------------------------------------------
module bank_port_arbiter import mem_pkg::*; #(
  parameter int unsigned AddrWidth  = 8,
  parameter int unsigned RouteDepth = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 rd_req_i,
  input  logic [AddrWidth-3:0] rd_addr_i,
  output logic                 rd_gnt_o,
  output logic                 rd_rvalid_o,
  input  logic                 wr_req_i,
  input  logic [AddrWidth-3:0] wr_addr_i,
  input  lane_t                wr_wdata_i,
  output logic                 wr_gnt_o,
  output logic                 wr_rvalid_o,
  output logic                 mem_req_o,
  output logic [AddrWidth-3:0] mem_addr_o,
  output lane_t                mem_wdata_o,
  output logic                 mem_we_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i
);

  localparam int unsigned PtrWidth = (RouteDepth > 1) ? $clog2(RouteDepth) : 1;

  // Set when the write side has priority on the next contended cycle.
  logic                wr_prio_q;
  logic                wr_win;
  logic                push;
  // One bit per granted request, 1 for the write side.
  logic                route_q [RouteDepth];
  logic [PtrWidth-1:0] push_ptr_q;
  logic [PtrWidth-1:0] pop_ptr_q;
  logic                route_head;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(RouteDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // The write side wins when it is alone or when it holds priority.
  assign wr_win = wr_req_i & (~rd_req_i | wr_prio_q);

  assign mem_req_o   = rd_req_i | wr_req_i;
  assign mem_addr_o  = wr_win ? wr_addr_i : rd_addr_i;
  assign mem_wdata_o = wr_wdata_i;
  assign mem_we_o    = wr_win;

  assign wr_gnt_o = wr_win & mem_gnt_i;
  assign rd_gnt_o = rd_req_i & ~wr_win & mem_gnt_i;

  // Responses come back in request order, so the FIFO head names the
  // side that owns the response arriving now.
  assign push        = mem_req_o & mem_gnt_i;
  assign route_head  = route_q[pop_ptr_q];
  assign wr_rvalid_o = mem_rvalid_i & route_head;
  assign rd_rvalid_o = mem_rvalid_i & ~route_head;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_prio_q  <= 1'b0;
      push_ptr_q <= '0;
      pop_ptr_q  <= '0;
    end else begin
      // The loser of a contended grant goes first next time.
      if (rd_req_i & wr_req_i & mem_gnt_i) begin
        wr_prio_q <= ~wr_win;
      end
      if (push) begin
        push_ptr_q <= next_ptr(push_ptr_q);
      end
      if (mem_rvalid_i) begin
        pop_ptr_q <= next_ptr(pop_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      route_q[push_ptr_q] <= wr_win;
    end
  end

endmodule

// File: hdl/mem_bank.sv
// ----------------------------------------------------------------------
// Behavioural model of one 8-bit-wide SRAM bank, one-cycle latency.
// ----------------------------------------------------------------------
module mem_bank import mem_pkg::*; #(
  parameter int unsigned AddrWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  output logic                 gnt_o,
  input  logic [AddrWidth-3:0] addr_i,
  input  lane_t                wdata_i,
  input  logic                 we_i,
  output logic                 rvalid_o,
  output lane_t                rdata_o
);

  lane_t mem_q [2**(AddrWidth-2)];
  logic  rvalid_q;
  lane_t rdata_q;

  // The bank takes a request on every cycle.
  assign gnt_o    = 1'b1;
  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // Writes answer too, so the arbiter can retire its route entry.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i & we_i) begin
      mem_q[addr_i] <= wdata_i;
    end else if (req_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

endmodule

// File: hdl/mem_pkg.sv
// ----------------------------------------------------------------------
// Shared constants and vector types of the banked SRAM subsystem.
// Also holds the OKAY response code and the converter FSM states.
// ----------------------------------------------------------------------
package mem_pkg;

  // Width of one AXI4-Lite data word.
  localparam int unsigned DataWidth = 32;
  // Number of memory banks, which is also the number of lanes per word.
  localparam int unsigned NumBanks = 4;
  // Each bank serves one byte lane of the word.
  localparam int unsigned LaneWidth = DataWidth / NumBanks;

  typedef logic [DataWidth-1:0] word_t;
  typedef logic [DataWidth/8-1:0] strb_t;
  typedef logic [LaneWidth-1:0] lane_t;
  // One bit per bank, for request, grant and response masks.
  typedef logic [NumBanks-1:0] bank_vec_t;
  typedef logic [1:0] resp_t;

  // Only OKAY is ever returned on B and R.
  localparam resp_t RespOkay = 2'b00;

  // States of the read and the write converter.
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RSP,
    RESP
  } conv_state_e;

endpackage

// File: hdl/mem_subsys_top.sv
// ----------------------------------------------------------------------
// Banked SRAM subsystem: AXI4-Lite slave port and four byte-wide banks.
// ----------------------------------------------------------------------
module mem_subsys_top import mem_pkg::*; #(
  parameter int unsigned AddrWidth = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  logic [AddrWidth-1:0] awaddr_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  word_t                wdata_i,
  input  strb_t                wstrb_i,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  output resp_t                bresp_o,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  input  logic [AddrWidth-1:0] araddr_i,
  output logic                 rvalid_o,
  input  logic                 rready_i,
  output word_t                rdata_o,
  output resp_t                rresp_o
);

  bank_vec_t                          mem_req, mem_gnt, mem_strb, mem_we, mem_rvalid;
  logic [NumBanks-1:0][AddrWidth-3:0] mem_addr;
  lane_t [NumBanks-1:0]               mem_wdata, mem_rdata;

  // The AXI port passes straight through by name.
  axil_to_mem_interleaved #(
    .AddrWidth(AddrWidth)
  ) axil_to_mem_interleaved_i (
    .*,
    .mem_req_o   (mem_req),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_strb_o  (mem_strb),
    .mem_we_o    (mem_we),
    .mem_gnt_i   (mem_gnt),
    .mem_rvalid_i(mem_rvalid),
    .mem_rdata_i (mem_rdata)
  );

  // A bank stores its byte only when both write enable and strobe are set.
  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    mem_bank #(
      .AddrWidth(AddrWidth)
    ) mem_bank_i (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .req_i   (mem_req[i]),
      .gnt_o   (mem_gnt[i]),
      .addr_i  (mem_addr[i]),
      .wdata_i (mem_wdata[i]),
      .we_i    (mem_we[i] & mem_strb[i]),
      .rvalid_o(mem_rvalid[i]),
      .rdata_o (mem_rdata[i])
    );
  end

endmodule

// File: list.f
hdl/mem_pkg.sv
hdl/axil_write_to_banks.sv
hdl/axil_read_to_banks.sv
hdl/bank_port_arbiter.sv
hdl/axil_to_mem_interleaved.sv
hdl/mem_bank.sv
hdl/mem_subsys_top.sv
tests/tb_mem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and judges the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --top-module tb_mem_subsys -f list.f --Mdir "$BUILD_DIR" -o sim_bin
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/sim_bin" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "tests failed" "$LOG_FILE"; then
  echo "Simulation reported failures, see $LOG_FILE"
  exit 1
fi

if ! grep -q "all tests passed" "$LOG_FILE"; then
  echo "Simulation ended without a result line, see $LOG_FILE"
  exit 1
fi

echo "Simulation passed"
exit 0

// File: tests/tb_mem_subsys.sv
// ----------------------------------------------------------------------
// Testbench for the banked SRAM subsystem. A table of AXI4-Lite writes,
// reads and paired accesses is checked against a byte-wide memory model.
// ----------------------------------------------------------------------
module tb_mem_subsys import mem_pkg::*; ();

  localparam int AddrWidth     = 8;
  localparam int HalfPeriod    = 20;
  // Outputs are sampled halfway through the low phase, well clear of both edges.
  localparam int SamplePoint   = 10;
  localparam int ResetCycles   = 16;
  localparam int NumRows       = 16;
  localparam int TimeoutCycles = NumRows * 40 + ResetCycles;
  localparam resp_t Okay       = 2'b00;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_PAIR
  } op_e;

  logic                 clk_i;
  logic                 rst_i;
  logic                 awvalid_i;
  logic                 awready_o;
  logic [AddrWidth-1:0] awaddr_i;
  logic                 wvalid_i;
  logic                 wready_o;
  word_t                wdata_i;
  strb_t                wstrb_i;
  logic                 bvalid_o;
  logic                 bready_i;
  resp_t                bresp_o;
  logic                 arvalid_i;
  logic                 arready_o;
  logic [AddrWidth-1:0] araddr_i;
  logic                 rvalid_o;
  logic                 rready_i;
  word_t                rdata_o;
  resp_t                rresp_o;

  // Stimulus table, one entry per row in each array.
  op_e                  row_op     [NumRows];
  logic [AddrWidth-1:0] row_waddr  [NumRows];
  strb_t                row_strb   [NumRows];
  logic [AddrWidth-1:0] row_raddr  [NumRows];
  int                   row_bstall [NumRows];
  int                   row_rstall [NumRows];
  int                   num_rows = 0;

  // Byte-addressed reference memory.
  logic [7:0] model_mem [2**AddrWidth];

  integer seed;
  int     errors      = 0;
  int     b_count     = 0;
  int     r_count     = 0;
  int     exp_writes  = 0;
  int     exp_reads   = 0;
  int     cycle_count = 0;

  mem_subsys_top #(
    .AddrWidth(AddrWidth)
  ) mem_subsys_top_i (
    .*
  );

  always #(HalfPeriod) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
  end

  // Counts every B and R handshake, sampled in the low phase before the
  // rising edge that completes it.
  always @(negedge clk_i) begin
    #(SamplePoint);
    if (bvalid_o && bready_i) begin
      b_count++;
    end
    if (rvalid_o && rready_i) begin
      r_count++;
    end
  end

  function automatic void add_row(input op_e op, input logic [AddrWidth-1:0] waddr,
                                  input strb_t strb, input logic [AddrWidth-1:0] raddr,
                                  input int bstall, input int rstall);
    row_op[num_rows]     = op;
    row_waddr[num_rows]  = waddr;
    row_strb[num_rows]   = strb;
    row_raddr[num_rows]  = raddr;
    row_bstall[num_rows] = bstall;
    row_rstall[num_rows] = rstall;
    num_rows++;
  endfunction

  // Every word that is read has been fully written first, since the
  // banks power up with unknown contents.
  task automatic load_table();
    add_row(OP_WRITE, 8'h00, 4'hf, 8'h00, 0, 0);
    add_row(OP_READ,  8'h00, 4'h0, 8'h00, 0, 0);
    add_row(OP_WRITE, 8'h04, 4'hf, 8'h00, 0, 0);
    add_row(OP_WRITE, 8'h04, 4'h5, 8'h00, 0, 0);
    add_row(OP_READ,  8'h00, 4'h0, 8'h04, 0, 0);
    add_row(OP_WRITE, 8'h08, 4'hf, 8'h00, 0, 0);
    add_row(OP_WRITE, 8'h08, 4'h0, 8'h00, 0, 0);
    add_row(OP_READ,  8'h00, 4'h0, 8'h08, 0, 0);
    add_row(OP_WRITE, 8'h0c, 4'hf, 8'h00, 0, 0);
    add_row(OP_PAIR,  8'h10, 4'hf, 8'h0c, 0, 0);
    add_row(OP_READ,  8'h00, 4'h0, 8'h10, 0, 0);
    add_row(OP_WRITE, 8'h14, 4'hf, 8'h00, 5, 0);
    add_row(OP_READ,  8'h00, 4'h0, 8'h14, 0, 4);
    add_row(OP_PAIR,  8'h0c, 4'ha, 8'h04, 3, 2);
    add_row(OP_READ,  8'h00, 4'h0, 8'h0c, 0, 1);
    add_row(OP_PAIR,  8'h08, 4'hc, 8'h14, 0, 6);
  endtask

  function automatic word_t model_read(input logic [AddrWidth-1:0] addr);
    word_t word;
    for (int b = 0; b < 4; b++) begin
      word[8*b +: 8] = model_mem[addr + AddrWidth'(b)];
    end
    return word;
  endfunction

  // Only the bytes whose strobe bit is set take the new data.
  function automatic void model_write(input logic [AddrWidth-1:0] addr, input word_t data,
                                      input strb_t strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_mem[addr + AddrWidth'(b)] = data[8*b +: 8];
      end
    end
  endfunction

  task automatic write_word(input logic [AddrWidth-1:0] addr, input word_t data,
                            input strb_t strb, input int stall);
    resp_t held_resp;
    @(negedge clk_i);
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = strb;
    #(SamplePoint);
    // AW and W are accepted together on one edge.
    while (!(awready_o && wready_o)) begin
      @(negedge clk_i);
      #(SamplePoint);
    end
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    #(SamplePoint);
    while (!bvalid_o) begin
      @(negedge clk_i);
      #(SamplePoint);
    end
    held_resp = bresp_o;
    if (bresp_o !== Okay) begin
      errors++;
      $display("FAIL %0t: write to 0x%02h got bresp %0d, expected OKAY", $time, addr, bresp_o);
    end
    // B must stay up unchanged while the master holds bready low.
    for (int c = 0; c < stall; c++) begin
      @(negedge clk_i);
      #(SamplePoint);
      if (bvalid_o !== 1'b1 || bresp_o !== held_resp) begin
        errors++;
        $display("FAIL %0t: B response dropped or changed during stall", $time);
      end
    end
    @(negedge clk_i);
    bready_i = 1'b1;
    #(SamplePoint);
    @(negedge clk_i);
    bready_i = 1'b0;
    #(SamplePoint);
    if (bvalid_o !== 1'b0) begin
      errors++;
      $display("FAIL %0t: bvalid_o still high after the B handshake", $time);
    end
  endtask

  task automatic read_word(input logic [AddrWidth-1:0] addr, input word_t expected,
                           input int stall);
    word_t held_data;
    @(negedge clk_i);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    #(SamplePoint);
    while (!arready_o) begin
      @(negedge clk_i);
      #(SamplePoint);
    end
    @(negedge clk_i);
    arvalid_i = 1'b0;
    #(SamplePoint);
    while (!rvalid_o) begin
      @(negedge clk_i);
      #(SamplePoint);
    end
    held_data = rdata_o;
    if (rdata_o !== expected || rresp_o !== Okay) begin
      errors++;
      $display("FAIL %0t: read at 0x%02h returned 0x%08h resp %0d, expected 0x%08h OKAY",
               $time, addr, rdata_o, rresp_o, expected);
    end
    for (int c = 0; c < stall; c++) begin
      @(negedge clk_i);
      #(SamplePoint);
      if (rvalid_o !== 1'b1 || rdata_o !== held_data) begin
        errors++;
        $display("FAIL %0t: R response dropped or changed during stall", $time);
      end
    end
    @(negedge clk_i);
    rready_i = 1'b1;
    #(SamplePoint);
    @(negedge clk_i);
    rready_i = 1'b0;
    #(SamplePoint);
    if (rvalid_o !== 1'b0) begin
      errors++;
      $display("FAIL %0t: rvalid_o still high after the R handshake", $time);
    end
  endtask

  // The expected read word is taken before the row's write lands, which
  // is what a PAIR row must see at its separate address.
  task automatic run_row(input int i);
    word_t data;
    word_t expected;
    data     = $random(seed);
    expected = model_read(row_raddr[i]);
    case (row_op[i])
      OP_WRITE: begin
        write_word(row_waddr[i], data, row_strb[i], row_bstall[i]);
        model_write(row_waddr[i], data, row_strb[i]);
        exp_writes++;
      end
      OP_READ: begin
        read_word(row_raddr[i], expected, row_rstall[i]);
        exp_reads++;
      end
      default: begin
        fork
          write_word(row_waddr[i], data, row_strb[i], row_bstall[i]);
          read_word(row_raddr[i], expected, row_rstall[i]);
        join
        model_write(row_waddr[i], data, row_strb[i]);
        exp_writes++;
        exp_reads++;
      end
    endcase
  endtask

  initial begin
    seed      = 32'h2b7a0eb4;
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    awvalid_i = 1'b0;
    awaddr_i  = '0;
    wvalid_i  = 1'b0;
    wdata_i   = '0;
    wstrb_i   = '0;
    bready_i  = 1'b0;
    arvalid_i = 1'b0;
    araddr_i  = '0;
    rready_i  = 1'b0;
    load_table();
    repeat (ResetCycles) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    // With no request pending, neither response channel may fire and no
    // request channel may be ready.
    repeat (3) begin
      #(SamplePoint);
      if (bvalid_o !== 1'b0 || rvalid_o !== 1'b0 ||
          awready_o !== 1'b0 || wready_o !== 1'b0 || arready_o !== 1'b0) begin
        errors++;
        $display("FAIL %0t: valid or ready high after reset with no request", $time);
      end
      @(negedge clk_i);
    end
    for (int i = 0; i < num_rows; i++) begin
      run_row(i);
    end
    if (b_count != exp_writes || r_count != exp_reads) begin
      errors++;
      $display("FAIL %0t: saw %0d B and %0d R handshakes, expected %0d and %0d",
               $time, b_count, r_count, exp_writes, exp_reads);
    end
    $display("errors: %0d, B responses: %0d of %0d, R responses: %0d of %0d",
             errors, b_count, exp_writes, r_count, exp_reads);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    wait (cycle_count >= TimeoutCycles);
    $display("Timeout, the run did not finish within %0d cycles.", TimeoutCycles);
    $display("tests failed");
    $finish;
  end

endmodule
